// File: all.f
logic/decodePkg.sv
logic/instrBuffer.sv
logic/controlDecoder.sv
logic/operandUnit.sv
logic/decodeOutReg.sv
logic/decodeStage.sv
verification/decodeStage_asserts.sv
verification/decodeStageTb.sv

// File: logic/controlDecoder.sv
// Combinational opcode table; SIIC and RTI only raise a flag or pass NOP, halt is a field and stops nothing
`timescale 1ns/1ps
module controlDecoder (
    input  decodePkg::opcodeE   opcode,
    output logic                regWrite,
    output logic                memEnable,
    output logic                memWr,
    output logic                aluUseImm,
    output logic                halt,
    output logic                siic,
    output decodePkg::wbSrcE    wbSrc,
    output decodePkg::destSelE  destSel,
    output decodePkg::immSelE   immSel,
    output decodePkg::jumpKindE jumpKind,
    output decodePkg::linkE     link,
    output decodePkg::opcodeE   aluOp
);

    always_comb begin
        regWrite  = 1'b0; // Every field idles at zero
        memEnable = 1'b0;
        memWr     = 1'b0;
        aluUseImm = 1'b0;
        halt      = 1'b0;
        siic      = 1'b0;
        wbSrc     = decodePkg::aluOut;
        destSel   = decodePkg::rsField;
        immSel    = decodePkg::zero5;
        jumpKind  = decodePkg::jmpNone;
        link      = decodePkg::linkNone;
        aluOp     = opcode; // ALU sees the opcode itself
        unique case (opcode)
            decodePkg::opHalt: halt = 1'b1;
            decodePkg::opNop:  ;
            decodePkg::opSiic: siic = 1'b1;
            decodePkg::opRti:  aluOp = decodePkg::opNop;
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opRoli,
            decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli: begin
                regWrite  = 1'b1;
                aluUseImm = 1'b1;
                destSel   = decodePkg::rdI;
                immSel    = decodePkg::sign5;
            end
            decodePkg::opXori, decodePkg::opAndni: begin // Logic ops take an unsigned field
                regWrite  = 1'b1;
                aluUseImm = 1'b1;
                destSel   = decodePkg::rdI;
                immSel    = decodePkg::zero5;
            end
            decodePkg::opSt: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluUseImm = 1'b1; // Address is Rs plus offset
                destSel   = decodePkg::rdI;
                immSel    = decodePkg::sign5;
            end
            decodePkg::opLd: begin
                regWrite  = 1'b1;
                memEnable = 1'b1;
                aluUseImm = 1'b1;
                wbSrc     = decodePkg::memOut;
                destSel   = decodePkg::rdI;
                immSel    = decodePkg::sign5;
            end
            decodePkg::opStu: begin
                regWrite  = 1'b1; // Updated address goes back to Rs
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluUseImm = 1'b1;
                immSel    = decodePkg::sign5;
            end
            decodePkg::opBtr, decodePkg::opAluShift, decodePkg::opAluArith,
            decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco: begin
                regWrite = 1'b1;
                destSel  = decodePkg::rdR;
            end
            decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez: begin
                immSel   = decodePkg::sign8;
                jumpKind = decodePkg::jmpBranch;
            end
            decodePkg::opLbi: begin
                regWrite  = 1'b1;
                aluUseImm = 1'b1;
                immSel    = decodePkg::sign8;
                link      = decodePkg::linkLbi;
            end
            decodePkg::opSlbi: begin
                regWrite  = 1'b1; // Rs shifted left 8 then ORed
                aluUseImm = 1'b1;
                immSel    = decodePkg::zero8;
            end
            decodePkg::opJ: begin
                immSel   = decodePkg::sign11;
                jumpKind = decodePkg::jmpPcRel;
            end
            decodePkg::opJal: begin
                regWrite = 1'b1;
                destSel  = decodePkg::r7;
                immSel   = decodePkg::sign11;
                jumpKind = decodePkg::jmpPcRel;
                link     = decodePkg::linkPc;
            end
            decodePkg::opJr: begin
                immSel   = decodePkg::sign8;
                jumpKind = decodePkg::jmpRegRel;
            end
            decodePkg::opJalr: begin
                regWrite = 1'b1;
                destSel  = decodePkg::r7;
                immSel   = decodePkg::sign8;
                jumpKind = decodePkg::jmpRegRel;
                link     = decodePkg::linkPc;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/decodeOutReg.sv
// One-deep output register; all fields hold while outValid is high and outReady is low
`timescale 1ns/1ps
module decodeOutReg (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           bufValid,
    output logic                           bufReady,
    input  logic                           decRegWrite,
    input  logic                           decMemEnable,
    input  logic                           decMemWr,
    input  logic                           decAluUseImm,
    input  logic                           decHalt,
    input  logic                           decSiic,
    input  decodePkg::wbSrcE               decWbSrc,
    input  decodePkg::destSelE             decDestSel,
    input  decodePkg::immSelE              decImmSel,
    input  decodePkg::jumpKindE            decJumpKind,
    input  decodePkg::linkE                decLink,
    input  decodePkg::opcodeE              decAluOp,
    input  logic [decodePkg::dataW-1:0]    decRsData,
    input  logic [decodePkg::dataW-1:0]    decRtData,
    input  logic [decodePkg::dataW-1:0]    decImm,
    input  logic [decodePkg::regAddrW-1:0] decDestReg,
    output logic                           outValid,
    input  logic                           outReady,
    output logic                           regWrite,
    output logic                           memEnable,
    output logic                           memWr,
    output logic                           aluUseImm,
    output logic                           halt,
    output logic                           siic,
    output decodePkg::wbSrcE               wbSrc,
    output decodePkg::destSelE             destSel,
    output decodePkg::immSelE              immSel,
    output decodePkg::jumpKindE            jumpKind,
    output decodePkg::linkE                link,
    output decodePkg::opcodeE              aluOp,
    output logic [decodePkg::dataW-1:0]    rsData,
    output logic [decodePkg::dataW-1:0]    rtData,
    output logic [decodePkg::dataW-1:0]    imm,
    output logic [decodePkg::regAddrW-1:0] destReg
);

    assign bufReady = !outValid || outReady; // Empty or being consumed

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (bufReady) begin
            outValid <= bufValid;
        end
    end

    // Operands are frozen here so later writebacks leave them alone
    always_ff @(posedge clk) begin
        if (bufValid && bufReady) begin
            regWrite  <= decRegWrite;
            memEnable <= decMemEnable;
            memWr     <= decMemWr;
            aluUseImm <= decAluUseImm;
            halt      <= decHalt;
            siic      <= decSiic;
            wbSrc     <= decWbSrc;
            destSel   <= decDestSel;
            immSel    <= decImmSel;
            jumpKind  <= decJumpKind;
            link      <= decLink;
            aluOp     <= decAluOp;
            rsData    <= decRsData;
            rtData    <= decRtData;
            imm       <= decImm;
            destReg   <= decDestReg;
        end
    end

endmodule

// File: logic/decodePkg.sv
// Shared widths and decode encodings for the 16-bit eight-register core; the opcode map is fixed and complete
package decodePkg;

    localparam int dataW   = 16; // Instruction and data word
    localparam int regAddrW = 3; // Eight registers
    localparam int numRegs = 8;
    localparam int opcodeW = 5;  // Major opcode in bits 15:11

    typedef enum logic [opcodeW-1:0] {
        opHalt     = 5'b00000,
        opNop      = 5'b00001,
        opSiic     = 5'b00010, // Decoded as a flagged no-op
        opRti      = 5'b00011, // Decoded as a no-op
        opJ        = 5'b00100,
        opJr       = 5'b00101,
        opJal      = 5'b00110,
        opJalr     = 5'b00111,
        opAddi     = 5'b01000,
        opSubi     = 5'b01001,
        opXori     = 5'b01010,
        opAndni    = 5'b01011,
        opBeqz     = 5'b01100,
        opBnez     = 5'b01101,
        opBltz     = 5'b01110,
        opBgez     = 5'b01111,
        opSt       = 5'b10000,
        opLd       = 5'b10001,
        opSlbi     = 5'b10010,
        opStu      = 5'b10011,
        opRoli     = 5'b10100,
        opSlli     = 5'b10101,
        opRori     = 5'b10110,
        opSrli     = 5'b10111,
        opLbi      = 5'b11000,
        opBtr      = 5'b11001,
        opAluShift = 5'b11010, // ROL SLL ROR SRL picked by the function bits
        opAluArith = 5'b11011, // ADD SUB XOR ANDN picked by the function bits
        opSeq      = 5'b11100,
        opSlt      = 5'b11101,
        opSle      = 5'b11110,
        opSco      = 5'b11111
    } opcodeE;

    typedef enum logic [1:0] {
        rsField = 2'b00, // Bits 10:8
        rdR     = 2'b01, // Bits 4:2
        r7      = 2'b10, // Link register
        rdI     = 2'b11  // Bits 7:5
    } destSelE;

    // MSB selects sign extension and the low bits the field size
    typedef enum logic [2:0] {
        zero5  = 3'b000,
        zero8  = 3'b001,
        sign5  = 3'b100,
        sign8  = 3'b101,
        sign11 = 3'b110
    } immSelE;

    typedef enum logic {
        aluOut = 1'b0,
        memOut = 1'b1
    } wbSrcE;

    typedef enum logic [1:0] {
        jmpNone   = 2'b00,
        jmpBranch = 2'b01, // Conditional and PC relative
        jmpPcRel  = 2'b10, // J and JAL
        jmpRegRel = 2'b11  // JR and JALR
    } jumpKindE;

    typedef enum logic [1:0] {
        linkNone = 2'b00,
        linkLbi  = 2'b01, // Load immediate into Rs
        linkPc   = 2'b10  // R7 gets PC + 2
    } linkE;

endpackage

// File: logic/decodeStage.sv
// Decode stage top; two cycles from input accept to outValid, no hazard detection or forwarding
`timescale 1ns/1ps
module decodeStage (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           inValid,
    input  logic [decodePkg::dataW-1:0]    inInstr,
    output logic                           inReady,
    input  logic                           wbEn,
    input  logic [decodePkg::regAddrW-1:0] wbAddr,
    input  logic [decodePkg::dataW-1:0]    wbData,
    output logic                           outValid,
    input  logic                           outReady,
    output logic                           regWrite,
    output logic                           memEnable,
    output logic                           memWr,
    output logic                           aluUseImm,
    output logic                           halt,
    output logic                           siic,
    output decodePkg::wbSrcE               wbSrc,
    output decodePkg::destSelE             destSel,
    output decodePkg::immSelE              immSel,
    output decodePkg::jumpKindE            jumpKind,
    output decodePkg::linkE                link,
    output decodePkg::opcodeE              aluOp,
    output logic [decodePkg::dataW-1:0]    rsData,
    output logic [decodePkg::dataW-1:0]    rtData,
    output logic [decodePkg::dataW-1:0]    imm,
    output logic [decodePkg::regAddrW-1:0] destReg
);

    logic                           bufValid;
    logic                           bufReady;
    logic [decodePkg::dataW-1:0]    bufInstr;
    logic                           decRegWrite;
    logic                           decMemEnable;
    logic                           decMemWr;
    logic                           decAluUseImm;
    logic                           decHalt;
    logic                           decSiic;
    decodePkg::wbSrcE               decWbSrc;
    decodePkg::destSelE             decDestSel;
    decodePkg::immSelE              decImmSel;
    decodePkg::jumpKindE            decJumpKind;
    decodePkg::linkE                decLink;
    decodePkg::opcodeE              decAluOp;
    logic [decodePkg::dataW-1:0]    decRsData;
    logic [decodePkg::dataW-1:0]    decRtData;
    logic [decodePkg::dataW-1:0]    decImm;
    logic [decodePkg::regAddrW-1:0] decDestReg;

    instrBuffer inBuf (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inInstr(inInstr), .inReady(inReady),
        .bufValid(bufValid), .bufInstr(bufInstr), .bufReady(bufReady)
    );

    controlDecoder ctrl (
        .opcode(decodePkg::opcodeE'(bufInstr[15:11])), // Major opcode field
        .regWrite(decRegWrite), .memEnable(decMemEnable), .memWr(decMemWr),
        .aluUseImm(decAluUseImm), .halt(decHalt), .siic(decSiic),
        .wbSrc(decWbSrc), .destSel(decDestSel), .immSel(decImmSel),
        .jumpKind(decJumpKind), .link(decLink), .aluOp(decAluOp)
    );

    operandUnit operands (
        .clk(clk), .rstN(rstN),
        .instr(bufInstr), .immSel(decImmSel), .destSel(decDestSel),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .rsData(decRsData), .rtData(decRtData), .imm(decImm), .destReg(decDestReg)
    );

    decodeOutReg outReg (
        .clk(clk), .rstN(rstN),
        .bufValid(bufValid), .bufReady(bufReady),
        .decRegWrite(decRegWrite), .decMemEnable(decMemEnable), .decMemWr(decMemWr),
        .decAluUseImm(decAluUseImm), .decHalt(decHalt), .decSiic(decSiic),
        .decWbSrc(decWbSrc), .decDestSel(decDestSel), .decImmSel(decImmSel),
        .decJumpKind(decJumpKind), .decLink(decLink), .decAluOp(decAluOp),
        .decRsData(decRsData), .decRtData(decRtData), .decImm(decImm),
        .decDestReg(decDestReg),
        .outValid(outValid), .outReady(outReady),
        .regWrite(regWrite), .memEnable(memEnable), .memWr(memWr),
        .aluUseImm(aluUseImm), .halt(halt), .siic(siic),
        .wbSrc(wbSrc), .destSel(destSel), .immSel(immSel),
        .jumpKind(jumpKind), .link(link), .aluOp(aluOp),
        .rsData(rsData), .rtData(rtData), .imm(imm), .destReg(destReg)
    );

endmodule

// File: logic/instrBuffer.sv
// One-word input holding register; the producer must keep inValid and inInstr stable until taken
`timescale 1ns/1ps
module instrBuffer (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    input  logic [decodePkg::dataW-1:0] inInstr,
    output logic                        inReady,
    output logic                        bufValid,
    output logic [decodePkg::dataW-1:0] bufInstr,
    input  logic                        bufReady
);

    // Accept when empty or when the held word leaves this cycle
    assign inReady = !bufValid || bufReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bufValid <= 1'b0;
        end else if (inReady) begin
            bufValid <= inValid; // Clears on hand-off with nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            bufInstr <= inInstr; // Payload only
        end
    end

endmodule

// File: logic/operandUnit.sv
// Eight-entry register file with asynchronous reads; a same-cycle write is seen only from the next cycle
`timescale 1ns/1ps
module operandUnit (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [decodePkg::dataW-1:0]    instr,
    input  decodePkg::immSelE              immSel,
    input  decodePkg::destSelE             destSel,
    input  logic                           wbEn,
    input  logic [decodePkg::regAddrW-1:0] wbAddr,
    input  logic [decodePkg::dataW-1:0]    wbData,
    output logic [decodePkg::dataW-1:0]    rsData,
    output logic [decodePkg::dataW-1:0]    rtData,
    output logic [decodePkg::dataW-1:0]    imm,
    output logic [decodePkg::regAddrW-1:0] destReg
);

    logic [decodePkg::dataW-1:0] regs [decodePkg::numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < decodePkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wbAddr] <= wbData; // Writeback from a later stage
        end
    end

    assign rsData = regs[instr[10:8]]; // Rs field
    assign rtData = regs[instr[7:5]];  // Rt field

    always_comb begin
        unique case (immSel)
            decodePkg::zero5:  imm = {{(decodePkg::dataW-5){1'b0}}, instr[4:0]};
            decodePkg::zero8:  imm = {{(decodePkg::dataW-8){1'b0}}, instr[7:0]};
            decodePkg::sign5:  imm = {{(decodePkg::dataW-5){instr[4]}}, instr[4:0]};
            decodePkg::sign8:  imm = {{(decodePkg::dataW-8){instr[7]}}, instr[7:0]};
            decodePkg::sign11: imm = {{(decodePkg::dataW-11){instr[10]}}, instr[10:0]};
            default:           imm = '0; // Unused encodings
        endcase
    end

    always_comb begin
        unique case (destSel)
            decodePkg::rsField: destReg = instr[10:8];
            decodePkg::rdR:     destReg = instr[4:2];
            decodePkg::r7:      destReg = 3'd7;
            decodePkg::rdI:     destReg = instr[7:5];
            default:            destReg = instr[10:8];
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator; exit status follows the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module decodeStageTb -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1
grep -q "TB PASSED" sim.log 2>/dev/null && echo "Simulation passed" || {
    echo "Simulation failed, see build.log and sim.log"
    exit 1
}

// File: verification/decodeStageTb.sv
// Testbench for decodeStage; inputs change on the falling edge and random data comes from a fixed-seed LFSR
`timescale 1ns/1ps
module decodeStageTb;

    localparam int  resetCycles = 10;
    localparam int  fillWords   = 8;
    localparam int  opWords     = 32;
    localparam int  randWords   = 200;
    localparam time clkPeriod   = 100ns;
    localparam time watchLimit  = clkPeriod *
                                  (resetCycles + 20 * (fillWords + opWords + randWords));

    logic                clk;
    logic                rstN;
    logic                inValid;
    logic [15:0]         inInstr;
    logic                inReady;
    logic                wbEn;
    logic [2:0]          wbAddr;
    logic [15:0]         wbData;
    logic                outValid;
    logic                outReady;
    logic                regWrite;
    logic                memEnable;
    logic                memWr;
    logic                aluUseImm;
    logic                halt;
    logic                siic;
    decodePkg::wbSrcE    wbSrc;
    decodePkg::destSelE  destSel;
    decodePkg::immSelE   immSel;
    decodePkg::jumpKindE jumpKind;
    decodePkg::linkE     link;
    decodePkg::opcodeE   aluOp;
    logic [15:0]         rsData;
    logic [15:0]         rtData;
    logic [15:0]         imm;
    logic [2:0]          destReg;

    logic [31:0] lfsr = 32'h94cc874e;
    logic [15:0] sentQ [$]; // Accepted words, oldest first
    string       testName;

    decodeStage UUT (.*);

    bind decodeStage decodeStage_asserts chk (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // Drive on one falling edge, settle, then log the handshakes of the coming rising edge
    task automatic driveCycle(input logic vld, input logic [15:0] w, input logic oRdy,
                              input logic wE, input logic [2:0] wA, input logic [15:0] wD,
                              output logic taken);
        logic [15:0] head;
        logic [4:0]  expOp;
        @(negedge clk);
        inValid  = vld;
        inInstr  = w;
        outReady = oRdy;
        wbEn     = wE;
        wbAddr   = wA;
        wbData   = wD;
        #1;
        taken = 1'b0;
        if (UUT.chk.failCount != 0) begin
            failRun("A bound assertion on the decode stage failed");
        end else if (outValid && outReady && sentQ.size() == 0) begin
            failRun("Output transfer with no word outstanding");
        end else begin
            if (outValid && outReady) begin
                head  = sentQ.pop_front();
                expOp = (head[15:11] == decodePkg::opRti) ? decodePkg::opNop : head[15:11];
                assert (UUT.chk.capInstr == head) else begin
                    $display("MISMATCH %s word expected %h actual %h", testName, head,
                             UUT.chk.capInstr);
                    failRun("Output entry is not the oldest accepted word");
                end
                assert (aluOp == expOp) else begin
                    $display("MISMATCH %s aluOp expected %h actual %h", testName, expOp, aluOp);
                    failRun("Wrong aluOp on output transfer");
                end
            end
            if (inValid && inReady) begin
                sentQ.push_back(inInstr);
                taken = 1'b1;
            end
        end
    endtask

    task automatic sendWord(input logic [15:0] w, input logic stall);
        logic        taken;
        logic        oRdy;
        logic [31:0] r;
        taken = 1'b0;
        while (!taken) begin
            oRdy = stall ? (takeBits(2) != 0) : 1'b1; // About one stall in four
            if (stall) begin
                r = takeBits(20); // Writeback enable, address and data
                driveCycle(1'b1, w, oRdy, r[19], r[18:16], r[15:0], taken);
            end else begin
                driveCycle(1'b1, w, oRdy, 1'b0, 3'd0, 16'd0, taken);
            end
        end
    endtask

    initial begin
        #(watchLimit);
        $display("Watchdog expired before all words drained");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic        taken;
        logic [31:0] r;
        clk      = 1'b0;
        rstN     = 1'b0;
        inValid  = 1'b0;
        inInstr  = '0;
        outReady = 1'b1;
        wbEn     = 1'b0;
        wbAddr   = '0;
        wbData   = '0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        testName = "regFill";
        for (int i = 0; i < fillWords; i++) begin
            r = takeBits(16);
            driveCycle(1'b0, 16'd0, 1'b1, 1'b1, i[2:0], r[15:0], taken);
        end

        testName = "allOpcodes";
        for (int op = 0; op < opWords; op++) begin
            r = takeBits(11);
            sendWord({op[4:0], r[10:0]}, 1'b0);
        end

        testName = "randomStall";
        for (int n = 0; n < randWords; n++) begin
            r = takeBits(16);
            sendWord(r[15:0], 1'b1);
        end

        testName = "drain";
        while (sentQ.size() != 0 || outValid) begin
            driveCycle(1'b0, 16'd0, 1'b1, 1'b0, 3'd0, 16'd0, taken);
        end
        repeat (3) driveCycle(1'b0, 16'd0, 1'b1, 1'b0, 3'd0, 16'd0, taken);

        if (UUT.chk.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("A bound assertion failed near the end of the run");
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// File: verification/decodeStage_asserts.sv
// Bound checker for decodeStage; expects sync active-low reset and reads internal buffer signals
`timescale 1ns/1ps
module decodeStage_asserts (
    input logic        clk,
    input logic        rstN,
    input logic        inValid,
    input logic        inReady,
    input logic        wbEn,
    input logic [2:0]  wbAddr,
    input logic [15:0] wbData,
    input logic        bufValid,
    input logic        bufReady,
    input logic [15:0] bufInstr,
    input logic        outValid,
    input logic        outReady,
    input logic        regWrite,
    input logic        memEnable,
    input logic        memWr,
    input logic        aluUseImm,
    input logic        halt,
    input logic        siic,
    input logic        wbSrc,
    input logic [1:0]  destSel,
    input logic [2:0]  immSel,
    input logic [1:0]  jumpKind,
    input logic [1:0]  link,
    input logic [4:0]  aluOp,
    input logic [15:0] rsData,
    input logic [15:0] rtData,
    input logic [15:0] imm,
    input logic [2:0]  destReg
);

    int unsigned failCount = 0; // Read by the testbench
    logic [15:0] shadow [8];     // Mirror of the register file
    logic [15:0] capInstr;       // Word held in the output register
    logic [15:0] capRs;
    logic [15:0] capRt;
    logic [14:0] expCtrl;
    logic [15:0] expImm;
    logic [2:0]  expDest;
    logic [14:0] outCtrl;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= '0;
            end
        end else if (wbEn) begin
            shadow[wbAddr] <= wbData;
        end
    end

    // Old shadow value is seen on a same-edge write
    always_ff @(posedge clk) begin
        if (bufValid && bufReady) begin
            capInstr <= bufInstr;
            capRs    <= shadow[bufInstr[10:8]];
            capRt    <= shadow[bufInstr[7:5]];
        end
    end

    // Packed as regWrite memEnable memWr halt siic wbSrc destSel immSel jumpKind link
    function automatic logic [14:0] ctrlFor(input logic [4:0] op);
        logic [14:0] c;
        c = '0;
        case (op)
            decodePkg::opHalt: c[14-3] = 1'b1;
            decodePkg::opSiic: c[14-4] = 1'b1;
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opRoli,
            decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli:
                c = {5'b10000, 1'b0, 2'b11, 3'b100, 2'b00, 2'b00};
            decodePkg::opXori, decodePkg::opAndni:
                c = {5'b10000, 1'b0, 2'b11, 3'b000, 2'b00, 2'b00};
            decodePkg::opSt:  c = {5'b01100, 1'b0, 2'b11, 3'b100, 2'b00, 2'b00};
            decodePkg::opLd:  c = {5'b11000, 1'b1, 2'b11, 3'b100, 2'b00, 2'b00};
            decodePkg::opStu: c = {5'b11100, 1'b0, 2'b00, 3'b100, 2'b00, 2'b00};
            decodePkg::opBtr, decodePkg::opAluShift, decodePkg::opAluArith,
            decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco:
                c = {5'b10000, 1'b0, 2'b01, 3'b000, 2'b00, 2'b00};
            decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez:
                c = {5'b00000, 1'b0, 2'b00, 3'b101, 2'b01, 2'b00};
            decodePkg::opLbi:  c = {5'b10000, 1'b0, 2'b00, 3'b101, 2'b00, 2'b01};
            decodePkg::opSlbi: c = {5'b10000, 1'b0, 2'b00, 3'b001, 2'b00, 2'b00};
            decodePkg::opJ:    c = {5'b00000, 1'b0, 2'b00, 3'b110, 2'b10, 2'b00};
            decodePkg::opJal:  c = {5'b10000, 1'b0, 2'b10, 3'b110, 2'b10, 2'b10};
            decodePkg::opJr:   c = {5'b00000, 1'b0, 2'b00, 3'b101, 2'b11, 2'b00};
            decodePkg::opJalr: c = {5'b10000, 1'b0, 2'b10, 3'b101, 2'b11, 2'b10};
            default: c = '0; // Nop and RTI
        endcase
        return c;
    endfunction

    // Immediate is the second ALU operand for I-format ALU ops, memory ops and byte loads
    function automatic logic immToAlu(input logic [4:0] op);
        case (op)
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
            decodePkg::opRoli, decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli,
            decodePkg::opSt, decodePkg::opLd, decodePkg::opStu,
            decodePkg::opLbi, decodePkg::opSlbi: return 1'b1;
            default: return 1'b0; // Branch and jump offsets go to the PC adder
        endcase
    endfunction

    always_comb begin
        expCtrl = ctrlFor(capInstr[15:11]);
        outCtrl = {regWrite, memEnable, memWr, halt, siic, wbSrc, destSel, immSel,
                   jumpKind, link};
        case (expCtrl[6:4]) // Expected immediate form
            3'b000:  expImm = {11'b0, capInstr[4:0]};
            3'b001:  expImm = {8'b0, capInstr[7:0]};
            3'b100:  expImm = {{11{capInstr[4]}}, capInstr[4:0]};
            3'b101:  expImm = {{8{capInstr[7]}}, capInstr[7:0]};
            default: expImm = {{5{capInstr[10]}}, capInstr[10:0]};
        endcase
        case (expCtrl[8:7]) // Expected destination select
            2'b00:   expDest = capInstr[10:8];
            2'b01:   expDest = capInstr[4:2];
            2'b10:   expDest = 3'd7;
            default: expDest = capInstr[7:5];
        endcase
    end

    resetState: assert property (@(posedge clk) $rose(rstN) |-> !outValid && inReady)
        else begin
            $error("outValid or inReady wrong after reset");
            failCount++;
        end
    latency: assert property (@(posedge clk) disable iff (!rstN)
        (inValid && inReady) ##1 outReady |=> outValid)
        else begin
            $error("Accepted word missed its two-cycle slot");
            failCount++;
        end
    noPhantom: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outValid) |-> $past(bufValid))
        else begin
            $error("outValid rose with nothing buffered");
            failCount++;
        end
    holdFields: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable({outCtrl, aluUseImm, aluOp,
        rsData, rtData, imm, destReg}))
        else begin
            $error("Output changed under back-pressure");
            failCount++;
        end
    ctrlTable: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> outCtrl == expCtrl)
        else begin
            $error("Control fields differ from opcode table");
            failCount++;
        end
    immUse: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> aluUseImm == immToAlu(capInstr[15:11]))
        else begin
            $error("aluUseImm differs from opcode table");
            failCount++;
        end
    immDest: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> imm == expImm && destReg == expDest)
        else begin
            $error("Immediate or destination wrong");
            failCount++;
        end
    operandRead: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> rsData == capRs && rtData == capRt)
        else begin
            $error("Operand data differs from register file");
            failCount++;
        end

endmodule
